/* Makefile */
# Verilator build and run for the video_blend testbench

VERILATOR ?= verilator
TOP       ?= video_blend_tb
FILELIST  ?= video_blend.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* rtl/blend_alpha_prep.sv */
// ----------------------------------------
// stage 1: mode and alpha reduced to one weight pair
// A alpha only matters for the select priority test
// ----------------------------------------
module blend_alpha_prep (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  video_blend_pkg::argb_t         pix_a_i,
    input  video_blend_pkg::argb_t         pix_b_i,
    input  video_blend_pkg::video_sync_t   sync_i,
    input  logic                           blend_en_i,
    output video_blend_pkg::argb_t         pix_a_o,
    output video_blend_pkg::argb_t         pix_b_o,
    output video_blend_pkg::blend_weight_t weight_o,
    output video_blend_pkg::video_sync_t   sync_o
);

    import video_blend_pkg::*;

    // B wins priority only when its alpha MSB is set and A's is clear
    logic          sel_b;
    // unregistered weight pair
    blend_weight_t weight_d;
    // B alpha zero-extended to weight width
    logic [WEIGHT_W-1:0] alpha_b;

    always_comb begin
        sel_b   = pix_b_i.alpha[CHANNEL_W-1] & ~pix_a_i.alpha[CHANNEL_W-1];
        alpha_b = WEIGHT_W'(pix_b_i.alpha);
        if (blend_en_i) begin
            // blend: fg = alpha + 1, bg = 16 - alpha, sum is always 17
            weight_d.fg_w = alpha_b + WEIGHT_W'(1);
            weight_d.bg_w = WEIGHT_ONE - alpha_b;
        end else if (sel_b) begin
            // select, show B
            weight_d.fg_w = WEIGHT_ONE;
            weight_d.bg_w = '0;
        end else begin
            // select, show A
            weight_d.fg_w = '0;
            weight_d.bg_w = WEIGHT_ONE;
        end
    end

    // weights, both pixels and sync all registered together
    // so stage 2 sees one aligned set
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pix_a_o  <= '0;
            pix_b_o  <= '0;
            weight_o <= '0;
            sync_o   <= '0;
        end else begin
            pix_a_o  <= pix_a_i;
            pix_b_o  <= pix_b_i;
            weight_o <= weight_d;
            sync_o   <= sync_i;
        end
    end

endmodule

/* rtl/blend_channel.sv */
// ----------------------------------------
// stage 2: one color lane, mode-agnostic
// weights must sum to 17 or less, no saturation
// ----------------------------------------
module blend_channel (
    input  logic                                    clk,
    input  logic                                    arst_n_i,
    input  logic [video_blend_pkg::CHANNEL_W-1:0]   fg_i,
    input  logic [video_blend_pkg::CHANNEL_W-1:0]   bg_i,
    input  video_blend_pkg::blend_weight_t          weight_i,
    output logic [video_blend_pkg::CHANNEL_W-1:0]   chan_o
);

    import video_blend_pkg::*;

    // weighted foreground (B) and background (A)
    logic [SUM_W-1:0] fg_prod;
    logic [SUM_W-1:0] bg_prod;
    // max 17 * 15 = 255, top bit stays clear
    logic [SUM_W-1:0] sum;

    always_comb begin
        fg_prod = SUM_W'(fg_i) * SUM_W'(weight_i.fg_w);
        bg_prod = SUM_W'(bg_i) * SUM_W'(weight_i.bg_w);
        sum     = fg_prod + bg_prod;
    end

    // divide by 16, keep bits 7..4
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            chan_o <= '0;
        end else begin
            chan_o <= sum[2*CHANNEL_W-1:CHANNEL_W];
        end
    end

endmodule

/* rtl/blend_output_stage.sv */
// ----------------------------------------
// stage 3: packs lanes into rgb, gates color by de
// lane 0 is red, lane NUM_CHANNELS-1 is blue
// ----------------------------------------
module blend_output_stage (
    input  logic                               clk,
    input  logic                               arst_n_i,
    input  logic [video_blend_pkg::NUM_CHANNELS-1:0]
                 [video_blend_pkg::CHANNEL_W-1:0] chan_i,
    input  video_blend_pkg::video_sync_t       sync_i,
    output video_blend_pkg::rgb_t              pix_o,
    output video_blend_pkg::video_sync_t       sync_o
);

    import video_blend_pkg::*;

    // stage-1 sync held one cycle to meet the lane results
    video_sync_t sync_q;
    // lanes packed in r, g, b order
    rgb_t        pix_d;

    always_comb begin
        pix_d.r = chan_i[0];
        pix_d.g = chan_i[1];
        pix_d.b = chan_i[2];
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q <= '0;
        end else begin
            sync_q <= sync_i;
        end
    end

    // final register, sync and color leave together
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_o <= '0;
            pix_o  <= '0;
        end else begin
            sync_o <= sync_q;
            // blank outside display enable
            if (sync_q.de) begin
                pix_o <= pix_d;
            end else begin
                pix_o <= '0;
            end
        end
    end

endmodule

/* rtl/video_blend_pkg.sv */
// ----------------------------------------
// shared types and widths for the two-layer compositor
// weights are 0..16 so a 4 bit shift restores channel range
// ----------------------------------------
package video_blend_pkg;

    // one color channel, also the alpha width
    localparam int CHANNEL_W = 4;
    // r, g, b in that order
    localparam int NUM_CHANNELS = 3;
    // blend weight range 0..16 needs 5 bits
    localparam int WEIGHT_W = 5;
    // 4x5 bit products summed, max 255
    localparam int SUM_W = CHANNEL_W + WEIGHT_W;
    // full weight, passes a channel through unchanged
    localparam logic [WEIGHT_W-1:0] WEIGHT_ONE = WEIGHT_W'(16);

    // input pixel from either playfield
    typedef struct packed {
        logic [CHANNEL_W-1:0] alpha;
        logic [CHANNEL_W-1:0] r;
        logic [CHANNEL_W-1:0] g;
        logic [CHANNEL_W-1:0] b;
    } argb_t;

    // composited output pixel
    typedef struct packed {
        logic [CHANNEL_W-1:0] r;
        logic [CHANNEL_W-1:0] g;
        logic [CHANNEL_W-1:0] b;
    } rgb_t;

    // video timing bits, follow the pixels through every stage
    typedef struct packed {
        logic vsync;
        logic hsync;
        logic de;
    } video_sync_t;

    // foreground (B) and background (A) weights
    typedef struct packed {
        logic [WEIGHT_W-1:0] fg_w;
        logic [WEIGHT_W-1:0] bg_w;
    } blend_weight_t;

endpackage

/* rtl/video_blend_top.sv */
// ----------------------------------------
// B over A compositor, fixed 3 cycle latency
// one pixel per clock, stream never stalls
// ----------------------------------------
module video_blend_top (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  video_blend_pkg::argb_t       pix_a_i,
    input  video_blend_pkg::argb_t       pix_b_i,
    input  video_blend_pkg::video_sync_t sync_i,
    input  logic                         blend_en_i,
    output video_blend_pkg::rgb_t        pix_o,
    output video_blend_pkg::video_sync_t sync_o
);

    import video_blend_pkg::*;

    // stage 1 outputs
    argb_t         pix_a_s1;
    argb_t         pix_b_s1;
    blend_weight_t weight_s1;
    video_sync_t   sync_s1;

    // per-lane operands, index 0 is red
    logic [NUM_CHANNELS-1:0][CHANNEL_W-1:0] a_chan;
    logic [NUM_CHANNELS-1:0][CHANNEL_W-1:0] b_chan;
    // stage 2 results
    logic [NUM_CHANNELS-1:0][CHANNEL_W-1:0] chan_res;

    blend_alpha_prep blend_alpha_prep_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .pix_a_i    (pix_a_i),
        .pix_b_i    (pix_b_i),
        .sync_i     (sync_i),
        .blend_en_i (blend_en_i),
        .pix_a_o    (pix_a_s1),
        .pix_b_o    (pix_b_s1),
        .weight_o   (weight_s1),
        .sync_o     (sync_s1)
    );

    // reversed concat puts r at index 0
    assign a_chan = {pix_a_s1.b, pix_a_s1.g, pix_a_s1.r};
    assign b_chan = {pix_b_s1.b, pix_b_s1.g, pix_b_s1.r};

    // B is foreground, A background
    for (genvar k = 0; k < NUM_CHANNELS; k++) begin : gen_channel
        blend_channel blend_channel_inst (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .fg_i     (b_chan[k]),
            .bg_i     (a_chan[k]),
            .weight_i (weight_s1),
            .chan_o   (chan_res[k])
        );
    end

    blend_output_stage blend_output_stage_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .chan_i   (chan_res),
        .sync_i   (sync_s1),
        .pix_o    (pix_o),
        .sync_o   (sync_o)
    );

endmodule

/* verification/video_blend_properties.sv */
// ----------------------------------------
// port checks bound into video_blend_top
// latency check assumes one reset at start
// ----------------------------------------
module video_blend_properties (
    input logic                         clk,
    input logic                         arst_n_i,
    input video_blend_pkg::video_sync_t sync_i,
    input video_blend_pkg::rgb_t        pix_o,
    input video_blend_pkg::video_sync_t sync_o
);

    // failed assertions, read by the testbench at the end
    int fail_count = 0;

    // timing bits inactive through reset
    a_sync_in_reset: assert property (@(posedge clk) !arst_n_i |-> sync_o == '0)
        else begin
            $error("sync_o not zero while reset is asserted");
            fail_count++;
        end

    // no color outside display enable
    a_blank_no_de: assert property (@(posedge clk) disable iff (!arst_n_i)
        !sync_o.de |-> pix_o == '0)
        else begin
            $error("pix_o not zero while sync_o.de is low");
            fail_count++;
        end

    // fixed 3 cycle delay, once 3 edges have passed out of reset
    a_sync_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
        $past(arst_n_i, 3) |-> sync_o == $past(sync_i, 3))
        else begin
            $error("sync_o does not match sync_i from 3 cycles earlier");
            fail_count++;
        end

endmodule

bind video_blend_top video_blend_properties video_blend_properties_inst (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .sync_i   (sync_i),
    .pix_o    (pix_o),
    .sync_o   (sync_o)
);

/* verification/video_blend_tb.sv */
// ----------------------------------------
// directed tests against a reference model
// outputs checked on the falling edge, 3 cycles after drive
// ----------------------------------------
module video_blend_tb;

    import video_blend_pkg::*;

    // test lengths in clock cycles, used by the watchdog
    localparam int RESET_CYCLES  = 4;
    localparam int SELECT_PIXELS = 4;
    localparam int SWEEP_PIXELS  = 17;
    localparam int SYNC_PIXELS   = 64;
    localparam int STREAM_PIXELS = 200;
    localparam int PIPE_DEPTH    = 3;
    localparam int TOTAL_CYCLES  = 1 + RESET_CYCLES + SELECT_PIXELS + SWEEP_PIXELS
                                   + SYNC_PIXELS + STREAM_PIXELS + PIPE_DEPTH;
    localparam int MARGIN_CYCLES = 50;
    // de high, no sync pulses
    localparam video_sync_t DE_ONLY = 3'b001;

    logic        clk = 1'b1;
    logic        arst_n_i;
    argb_t       pix_a_i;
    argb_t       pix_b_i;
    video_sync_t sync_i;
    logic        blend_en_i;
    rgb_t        pix_o;
    video_sync_t sync_o;

    logic [15:0] lfsr_state = 16'd57543;
    // expected outputs, head is due at the next falling edge
    rgb_t        exp_pix_q[$];
    video_sync_t exp_sync_q[$];
    int          err_count = 0;
    int          check_count = 0;

    // starts high so the first edge is a falling one
    always #5 clk = ~clk;

    video_blend_top video_blend_top_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .pix_a_i    (pix_a_i),
        .pix_b_i    (pix_b_i),
        .sync_i     (sync_i),
        .blend_en_i (blend_en_i),
        .pix_o      (pix_o),
        .sync_o     (sync_o)
    );

    // 16 bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one LFSR step per bit taken
    task automatic get_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[14:0], lfsr_state[0]};
        end
    endtask

    task automatic rand_pixel(output argb_t p);
        logic [15:0] bits;
        get_bits(16, bits);
        p = bits;
    endtask

    // blend: (alpha+1)*B + (16-alpha)*A, then /16
    // select: B only if its alpha MSB is set and A's is clear
    function automatic logic [3:0] model_channel(input logic [3:0] a_c, input logic [3:0] b_c,
                                                 input logic [3:0] a_alpha,
                                                 input logic [3:0] b_alpha, input logic en);
        int mix;
        if (en) begin
            mix = ((int'(b_alpha) + 1) * int'(b_c) + (16 - int'(b_alpha)) * int'(a_c)) >> 4;
            return mix[3:0];
        end
        if (b_alpha[3] && !a_alpha[3]) begin
            return b_c;
        end
        return a_c;
    endfunction

    function automatic rgb_t model_pixel(input argb_t a, input argb_t b, input logic en,
                                         input logic de);
        rgb_t p;
        // blanked outside display enable
        if (!de) begin
            return '0;
        end
        p.r = model_channel(a.r, b.r, a.alpha, b.alpha, en);
        p.g = model_channel(a.g, b.g, a.alpha, b.alpha, en);
        p.b = model_channel(a.b, b.b, a.alpha, b.alpha, en);
        return p;
    endfunction

    task automatic compare_head();
        rgb_t        exp_pix;
        video_sync_t exp_sync;
        exp_pix  = exp_pix_q.pop_front();
        exp_sync = exp_sync_q.pop_front();
        check_count++;
        if (sync_o !== exp_sync) begin
            err_count++;
            $display("error: sync_o expected %h got %h at %0t", exp_sync, sync_o, $time);
        end
        if (pix_o !== exp_pix) begin
            err_count++;
            $display("error: pix_o expected %h got %h at %0t", exp_pix, pix_o, $time);
        end
    endtask

    // one pixel per falling edge, output of 3 cycles back checked first
    task automatic drive_pixel(input argb_t a, input argb_t b, input video_sync_t s,
                               input logic en);
        @(negedge clk);
        if (exp_pix_q.size() == PIPE_DEPTH) begin
            compare_head();
        end
        pix_a_i    = a;
        pix_b_i    = b;
        sync_i     = s;
        blend_en_i = en;
        exp_pix_q.push_back(model_pixel(a, b, en, s.de));
        exp_sync_q.push_back(s);
    endtask

    task automatic test_reset_state();
        argb_t       rnd_a;
        argb_t       rnd_b;
        logic [15:0] bits;
        @(negedge clk);
        arst_n_i = 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_count++;
            if (sync_o !== '0) begin
                err_count++;
                $display("error: sync_o expected %h got %h in reset", 3'h0, sync_o);
            end
            if (pix_o !== '0) begin
                err_count++;
                $display("error: pix_o expected %h got %h in reset", 12'h0, pix_o);
            end
            // input activity must not leak through reset
            rand_pixel(rnd_a);
            rand_pixel(rnd_b);
            get_bits(4, bits);
            pix_a_i    = rnd_a;
            pix_b_i    = rnd_b;
            sync_i     = bits[2:0];
            blend_en_i = bits[3];
        end
        // idle inputs at release, so the pipeline drains zeros
        pix_a_i    = '0;
        pix_b_i    = '0;
        sync_i     = '0;
        blend_en_i = 1'b0;
        arst_n_i   = 1'b1;
        for (int i = 0; i < PIPE_DEPTH; i++) begin
            exp_pix_q.push_back('0);
            exp_sync_q.push_back('0);
        end
    endtask

    task automatic test_select_priority();
        argb_t a;
        argb_t b;
        // i[0] sets A alpha MSB, i[1] sets B alpha MSB
        for (int i = 0; i < SELECT_PIXELS; i++) begin
            a = {i[0], 3'b101, 4'h1, 4'h2, 4'h3};
            b = {i[1], 3'b010, 4'hc, 4'hd, 4'he};
            drive_pixel(a, b, DE_ONLY, 1'b0);
        end
    endtask

    task automatic test_alpha_sweep();
        argb_t a;
        argb_t b;
        for (int al = 0; al < 16; al++) begin
            rand_pixel(a);
            rand_pixel(b);
            b.alpha = al[3:0];
            drive_pixel(a, b, DE_ONLY, 1'b1);
        end
        // opaque white B covers any A completely
        rand_pixel(a);
        b = 16'hffff;
        drive_pixel(a, b, DE_ONLY, 1'b1);
    endtask

    task automatic test_sync_alignment();
        argb_t       a;
        argb_t       b;
        logic [15:0] bits;
        for (int i = 0; i < SYNC_PIXELS; i++) begin
            rand_pixel(a);
            rand_pixel(b);
            get_bits(4, bits);
            drive_pixel(a, b, bits[2:0], bits[3]);
        end
    endtask

    // mode flips every pixel, three pixels in flight
    task automatic test_streaming();
        argb_t a;
        argb_t b;
        for (int i = 0; i < STREAM_PIXELS; i++) begin
            rand_pixel(a);
            rand_pixel(b);
            drive_pixel(a, b, DE_ONLY, i[0]);
        end
    endtask

    task automatic flush_pipeline();
        while (exp_pix_q.size() > 0) begin
            @(negedge clk);
            compare_head();
        end
    endtask

    initial begin
        arst_n_i   = 1'b1;
        pix_a_i    = '0;
        pix_b_i    = '0;
        sync_i     = '0;
        blend_en_i = 1'b0;
        test_reset_state();
        test_select_priority();
        test_alpha_sweep();
        test_sync_alignment();
        test_streaming();
        flush_pipeline();
        err_count += video_blend_top_inst.video_blend_properties_inst.fail_count;
        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((TOTAL_CYCLES + MARGIN_CYCLES) * 10);
        $display("run did not finish within %0d cycles", TOTAL_CYCLES + MARGIN_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* video_blend.f */
rtl/video_blend_pkg.sv
rtl/blend_alpha_prep.sv
rtl/blend_channel.sv
rtl/blend_output_stage.sv
rtl/video_blend_top.sv
verification/video_blend_properties.sv
verification/video_blend_tb.sv
